// ==== design/fuse_access_pkg.sv ====
// Access side types of the fuse subsystem
// Lifecycle ordering, bus identity, fuse words and completion codes
package fuse_access_pkg;

  ////////////////////////////////////////
  // Lifecycle
  ////////////////////////////////////////

  // Lifecycle states, strictly increasing
  // Numeric compare against a partition phase decides the write lock
  typedef enum logic [2:0] {
    lc_raw      = 3'd0,
    lc_test     = 3'd1,
    lc_dev      = 3'd2,
    lc_prod     = 3'd3,
    lc_prod_end = 3'd4,
    lc_rma      = 3'd5,
    lc_scrap    = 3'd6
  } lc_state_e;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  // Initiator identity as seen on the user field of the bus
  typedef logic [3:0] bus_user_t;

  // One fuse word
  typedef logic [15:0] fuse_data_t;

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////

  // Completion code of a direct access
  // Escalation outranks an access error
  typedef enum logic [1:0] {
    err_none      = 2'd0,
    err_access    = 2'd1,
    err_escalated = 2'd2
  } fuse_err_e;

endpackage

// ==== design/fuse_map_pkg.sv ====
// Memory map of the fuse array
// Four partitions, each closed by its digest word
package fuse_map_pkg;

  import fuse_access_pkg::*;

  ////////////////////////////////////////
  // Sizes and address types
  ////////////////////////////////////////

  // Array depth in 16 bit words
  parameter int NumWords = 64;

  // Partition count
  parameter int NumParts = 4;

  // Word address into the array
  typedef logic [5:0] fuse_addr_t;

  // Partition index
  typedef logic [1:0] part_idx_t;

  ////////////////////////////////////////
  // Partition table
  ////////////////////////////////////////

  // Last address of a partition is its digest word
  typedef struct packed {
    fuse_addr_t first_addr;
    fuse_addr_t last_addr;
    logic       secret;
    lc_state_e  lc_phase;
  } part_info_t;

  parameter part_info_t PartInfo [NumParts] = '{
    // P0 test unlock tokens
    '{first_addr: 6'd0,  last_addr: 6'd7,  secret: 1'b1, lc_phase: lc_test},
    // P1 manufacturing data
    '{first_addr: 6'd8,  last_addr: 6'd23, secret: 1'b0, lc_phase: lc_dev},
    // P2 production secrets
    '{first_addr: 6'd24, last_addr: 6'd39, secret: 1'b1, lc_phase: lc_prod},
    // P3 vendor area
    '{first_addr: 6'd40, last_addr: 6'd63, secret: 1'b0, lc_phase: lc_prod_end}
  };

  // Partition that owns an address
  // Table covers the whole array, so one entry always matches
  function automatic part_idx_t part_of(fuse_addr_t addr);
    part_idx_t idx;
    idx = '0;
    for (int i = 0; i < NumParts; i++) begin
      if (addr >= PartInfo[i].first_addr && addr <= PartInfo[i].last_addr) begin
        idx = part_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // True on the digest word of the owning partition
  function automatic logic is_digest_addr(fuse_addr_t addr);
    return addr == PartInfo[part_of(addr)].last_addr;
  endfunction

endpackage

// ==== design/fuse_axi_filter.sv ====
`timescale 1ns/1ps

// Initiator filter
// A restricted initiator may not write below the filter limit
module fuse_axi_filter
  import fuse_access_pkg::*;
  import fuse_map_pkg::*;
#(
  // Writes below this word address are checked
  parameter fuse_addr_t FILTER_LIMIT    = fuse_addr_t'(24),
  // Initiator that is kept out of the low range
  parameter bus_user_t  RESTRICTED_USER = 4'h5
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_valid_i,
  input  logic       cmd_write_i,
  input  fuse_addr_t cmd_addr_i,
  input  bus_user_t  cmd_user_i,
  output logic       discard_o
);

  ////////////////////////////////////////
  // Policy decode
  ////////////////////////////////////////

  logic user_hit;
  logic range_hit;
  logic discard_d;
  logic discard_q;

  // Identity match on the bus user field
  assign user_hit  = cmd_user_i == RESTRICTED_USER;

  // Low range only
  assign range_hit = cmd_addr_i < FILTER_LIMIT;

  // Reads always pass the filter
  assign discard_d = cmd_valid_i && cmd_write_i && user_hit && range_hit;

  ////////////////////////////////////////
  // Verdict register
  ////////////////////////////////////////

  // Lines up with the engine's stage 1 copy of the command
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      discard_q <= 1'b0;
    end else begin
      discard_q <= discard_d;
    end
  end

  assign discard_o = discard_q;

  // A discard only ever follows a strobed command
  assert property (@(posedge clk_i) disable iff (reset_i)
    !cmd_valid_i |=> !discard_o)
    else $error("filter discard without a command");

endmodule

// ==== design/fuse_part_lock.sv ====
`timescale 1ns/1ps

// Partition lock checker
// Write lock from lifecycle phase and digest, read lock on secret digests
module fuse_part_lock
  import fuse_access_pkg::*;
  import fuse_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_valid_i,
  input  logic       cmd_write_i,
  input  fuse_addr_t cmd_addr_i,
  input  lc_state_e  lc_state_i,
  // Writes performed by the engine
  input  logic       commit_i,
  input  fuse_addr_t commit_addr_i,
  input  fuse_data_t commit_wdata_i,
  output logic       lock_viol_o
);

  ////////////////////////////////////////
  // Digest lock flags
  ////////////////////////////////////////

  logic [NumParts-1:0] digest_lock_q;
  part_idx_t           commit_part;
  logic                commit_digest;

  assign commit_part   = part_of(commit_addr_i);

  // Nonzero data landing on a digest word closes the partition
  assign commit_digest = commit_i && is_digest_addr(commit_addr_i) &&
                         (commit_wdata_i != '0);

  // Flags only ever set, reset is the sole way back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      digest_lock_q <= '0;
    end else if (commit_digest) begin
      digest_lock_q[commit_part] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Command check
  ////////////////////////////////////////

  part_idx_t cmd_part;
  logic      lc_expired;
  logic      write_locked;
  logic      read_locked;
  logic      lock_viol_d;
  logic      lock_viol_q;

  assign cmd_part     = part_of(cmd_addr_i);

  // Phase of this partition is over once lifecycle moves past it
  assign lc_expired   = lc_state_i > PartInfo[cmd_part].lc_phase;

  // Digest word itself is covered too
  assign write_locked = lc_expired || digest_lock_q[cmd_part];

  // Non-secret partitions stay readable after the digest
  assign read_locked  = PartInfo[cmd_part].secret && digest_lock_q[cmd_part];

  assign lock_viol_d  = cmd_valid_i && (cmd_write_i ? write_locked : read_locked);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_viol_q <= 1'b0;
    end else begin
      lock_viol_q <= lock_viol_d;
    end
  end

  assign lock_viol_o = lock_viol_q;

  // Once locked, a partition stays locked until reset
  for (genvar i = 0; i < NumParts; i++) begin : g_sticky
    assert property (@(posedge clk_i) disable iff (reset_i)
      digest_lock_q[i] |=> digest_lock_q[i])
      else $error("digest lock of partition %0d dropped", i);
  end

endmodule

// ==== design/fuse_dai_engine.sv ====
`timescale 1ns/1ps

// Direct access engine
// Holds the array, resolves both verdicts and escalation, raises interrupts
module fuse_dai_engine
  import fuse_access_pkg::*;
  import fuse_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_valid_i,
  input  logic       cmd_write_i,
  input  fuse_addr_t cmd_addr_i,
  input  fuse_data_t cmd_wdata_i,
  // Registered verdicts, aligned with stage 1
  input  logic       discard_i,
  input  logic       lock_viol_i,
  input  logic       escalate_i,
  input  logic       intr_en_done_i,
  input  logic       intr_en_error_i,
  input  logic       intr_clear_i,
  output logic       done_o,
  output fuse_err_e  err_o,
  output fuse_data_t rdata_o,
  output logic       commit_o,
  output fuse_addr_t commit_addr_o,
  output fuse_data_t commit_wdata_o,
  output logic       intr_done_o,
  output logic       intr_error_o
);

  typedef enum logic {
    idle_run = 1'b0,
    terminal = 1'b1
  } dai_state_e;

  ////////////////////////////////////////
  // Escalation FSM
  ////////////////////////////////////////

  dai_state_e state_q;

  // Terminal state has no exit except reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= idle_run;
    end else if (escalate_i) begin
      state_q <= terminal;
    end
  end

  ////////////////////////////////////////
  // Stage 1 command copy
  ////////////////////////////////////////

  logic       s1_valid_q;
  logic       s1_write_q;
  fuse_addr_t s1_addr_q;
  fuse_data_t s1_wdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= cmd_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_write_q <= cmd_write_i;
    s1_addr_q  <= cmd_addr_i;
    s1_wdata_q <= cmd_wdata_i;
  end

  ////////////////////////////////////////
  // Stage 2 resolve and access
  ////////////////////////////////////////

  fuse_err_e  s1_err;
  logic       s1_ok;
  fuse_data_t mem_q [NumWords];

  // Escalation first, then either check
  always_comb begin
    if (state_q == terminal) begin
      s1_err = err_escalated;
    end else if (discard_i || lock_viol_i) begin
      s1_err = err_access;
    end else begin
      s1_err = err_none;
    end
  end

  assign s1_ok = s1_valid_q && (s1_err == err_none);

  // Fuse array, cleared on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (s1_ok && s1_write_q) begin
      mem_q[s1_addr_q] <= s1_wdata_q;
    end
  end

  logic       done_q;
  logic       commit_q;
  fuse_err_e  err_q;
  fuse_data_t rdata_q;
  fuse_addr_t commit_addr_q;
  fuse_data_t commit_wdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q   <= 1'b0;
      commit_q <= 1'b0;
    end else begin
      done_q   <= s1_valid_q;
      commit_q <= s1_ok && s1_write_q;
    end
  end

  // Read data only for a clean read, zero otherwise
  always_ff @(posedge clk_i) begin
    err_q          <= s1_err;
    rdata_q        <= (s1_ok && !s1_write_q) ? mem_q[s1_addr_q] : '0;
    commit_addr_q  <= s1_addr_q;
    commit_wdata_q <= s1_wdata_q;
  end

  assign done_o         = done_q;
  assign err_o          = err_q;
  assign rdata_o        = rdata_q;
  assign commit_o       = commit_q;
  assign commit_addr_o  = commit_addr_q;
  assign commit_wdata_o = commit_wdata_q;

  ////////////////////////////////////////
  // Sticky interrupts
  ////////////////////////////////////////

  logic intr_done_q;
  logic intr_error_q;

  // A new event in the clearing cycle still sets the level
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_done_q  <= 1'b0;
      intr_error_q <= 1'b0;
    end else begin
      if (intr_clear_i) begin
        intr_done_q  <= 1'b0;
        intr_error_q <= 1'b0;
      end
      if (done_q && (err_q == err_none) && intr_en_done_i) begin
        intr_done_q <= 1'b1;
      end
      if (done_q && (err_q != err_none) && intr_en_error_i) begin
        intr_error_q <= 1'b1;
      end
    end
  end

  assign intr_done_o  = intr_done_q;
  assign intr_error_o = intr_error_q;

  // Escalation reaches the terminal state one cycle later
  assert property (@(posedge clk_i) disable iff (reset_i)
    escalate_i |=> state_q == terminal)
    else $error("escalation did not reach terminal state");

  // Only clean completions reach the lock checker as commits
  assert property (@(posedge clk_i) disable iff (reset_i)
    commit_o |-> (done_o && err_o == err_none))
    else $error("commit on a refused access");

endmodule

// ==== design/fuse_access_top.sv ====
`timescale 1ns/1ps

// Fuse access subsystem
// Filter and lock checker run side by side, engine merges their verdicts
module fuse_access_top
  import fuse_access_pkg::*;
  import fuse_map_pkg::*;
#(
  parameter fuse_addr_t FILTER_LIMIT    = fuse_addr_t'(24),
  parameter bus_user_t  RESTRICTED_USER = 4'h5
) (
  input  logic       clk_i,
  input  logic       reset_i,
  // Command strobe and payload
  input  logic       cmd_valid_i,
  input  logic       cmd_write_i,
  input  fuse_addr_t cmd_addr_i,
  input  bus_user_t  cmd_user_i,
  input  fuse_data_t cmd_wdata_i,
  // System state
  input  lc_state_e  lc_state_i,
  input  logic       escalate_i,
  // Interrupt control
  input  logic       intr_en_done_i,
  input  logic       intr_en_error_i,
  input  logic       intr_clear_i,
  // Completion
  output logic       done_o,
  output fuse_err_e  err_o,
  output fuse_data_t rdata_o,
  output logic       intr_done_o,
  output logic       intr_error_o
);

  ////////////////////////////////////////
  // Verdict and commit wires
  ////////////////////////////////////////

  logic       discard_q;
  logic       lock_viol_q;
  logic       commit;
  fuse_addr_t commit_addr;
  fuse_data_t commit_wdata;

  fuse_axi_filter #(
    .FILTER_LIMIT    (FILTER_LIMIT),
    .RESTRICTED_USER (RESTRICTED_USER)
  ) i_filter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_write_i (cmd_write_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_user_i  (cmd_user_i),
    .discard_o   (discard_q)
  );

  // Digest flags follow the engine's commits
  fuse_part_lock i_part_lock (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_write_i    (cmd_write_i),
    .cmd_addr_i     (cmd_addr_i),
    .lc_state_i     (lc_state_i),
    .commit_i       (commit),
    .commit_addr_i  (commit_addr),
    .commit_wdata_i (commit_wdata),
    .lock_viol_o    (lock_viol_q)
  );

  fuse_dai_engine i_engine (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_write_i     (cmd_write_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_wdata_i     (cmd_wdata_i),
    .discard_i       (discard_q),
    .lock_viol_i     (lock_viol_q),
    .escalate_i      (escalate_i),
    .intr_en_done_i  (intr_en_done_i),
    .intr_en_error_i (intr_en_error_i),
    .intr_clear_i    (intr_clear_i),
    .done_o          (done_o),
    .err_o           (err_o),
    .rdata_o         (rdata_o),
    .commit_o        (commit),
    .commit_addr_o   (commit_addr),
    .commit_wdata_o  (commit_wdata),
    .intr_done_o     (intr_done_o),
    .intr_error_o    (intr_error_o)
  );

endmodule

// ==== test/fuse_access_tb_table.svh ====
`ifndef FUSE_ACCESS_TB_TABLE_SVH
`define FUSE_ACCESS_TB_TABLE_SVH

// Columns: write, addr, user, wdata, lifecycle, escalate, expected err, expected rdata
// Rows below NUM_PRE run before escalation, the rest with escalate held high

localparam int NUM_ROWS = 31;
localparam int NUM_PRE  = 26;

localparam row_t ROWS [NUM_ROWS] = '{
  // Plain write and read-back in P1 and P3
  '{1'b1, 6'd10, 4'h0, 16'h1234, lc_dev,      1'b0, err_none,      16'h0000},
  '{1'b0, 6'd10, 4'h0, 16'h0000, lc_dev,      1'b0, err_none,      16'h1234},
  '{1'b1, 6'd45, 4'h0, 16'hbeef, lc_prod,     1'b0, err_none,      16'h0000},
  '{1'b0, 6'd45, 4'h0, 16'h0000, lc_prod,     1'b0, err_none,      16'hbeef},
  // Restricted user below the filter limit
  '{1'b1, 6'd12, 4'h5, 16'hdead, lc_dev,      1'b0, err_access,    16'h0000},
  '{1'b0, 6'd12, 4'h5, 16'h0000, lc_dev,      1'b0, err_none,      16'h0000},
  '{1'b1, 6'd12, 4'h3, 16'hdead, lc_dev,      1'b0, err_none,      16'h0000},
  '{1'b0, 6'd12, 4'h3, 16'h0000, lc_dev,      1'b0, err_none,      16'hdead},
  // Restricted user above the limit passes
  '{1'b1, 6'd30, 4'h5, 16'hc0de, lc_prod,     1'b0, err_none,      16'h0000},
  '{1'b0, 6'd30, 4'h5, 16'h0000, lc_prod,     1'b0, err_none,      16'hc0de},
  // P1 write lock once lifecycle is past dev
  '{1'b1, 6'd9,  4'h0, 16'h5555, lc_prod,     1'b0, err_access,    16'h0000},
  '{1'b0, 6'd9,  4'h0, 16'h0000, lc_prod,     1'b0, err_none,      16'h0000},
  '{1'b1, 6'd9,  4'h0, 16'h5555, lc_dev,      1'b0, err_none,      16'h0000},
  '{1'b0, 6'd9,  4'h0, 16'h0000, lc_dev,      1'b0, err_none,      16'h5555},
  // P2 secret digest closes reads and writes
  '{1'b1, 6'd26, 4'h0, 16'h0a0a, lc_prod,     1'b0, err_none,      16'h0000},
  '{1'b1, 6'd39, 4'h0, 16'h00ff, lc_prod,     1'b0, err_none,      16'h0000},
  '{1'b0, 6'd26, 4'h0, 16'h0000, lc_prod,     1'b0, err_access,    16'h0000},
  '{1'b1, 6'd27, 4'h0, 16'h1357, lc_prod,     1'b0, err_access,    16'h0000},
  '{1'b0, 6'd39, 4'h0, 16'h0000, lc_prod,     1'b0, err_access,    16'h0000},
  '{1'b0, 6'd30, 4'h0, 16'h0000, lc_prod,     1'b0, err_access,    16'h0000},
  // P3 digest blocks writes only
  '{1'b1, 6'd50, 4'h0, 16'h1111, lc_prod_end, 1'b0, err_none,      16'h0000},
  '{1'b1, 6'd63, 4'h0, 16'h7777, lc_prod_end, 1'b0, err_none,      16'h0000},
  '{1'b0, 6'd50, 4'h0, 16'h0000, lc_prod_end, 1'b0, err_none,      16'h1111},
  '{1'b0, 6'd63, 4'h0, 16'h0000, lc_prod_end, 1'b0, err_none,      16'h7777},
  '{1'b1, 6'd51, 4'h0, 16'h2222, lc_prod_end, 1'b0, err_access,    16'h0000},
  '{1'b0, 6'd10, 4'h0, 16'h0000, lc_prod_end, 1'b0, err_none,      16'h1234},
  // Escalated, nothing may change
  '{1'b1, 6'd10, 4'h0, 16'hffff, lc_dev,      1'b1, err_escalated, 16'h0000},
  '{1'b0, 6'd10, 4'h0, 16'h0000, lc_dev,      1'b1, err_escalated, 16'h0000},
  '{1'b1, 6'd45, 4'h0, 16'hffff, lc_prod,     1'b1, err_escalated, 16'h0000},
  '{1'b0, 6'd45, 4'h0, 16'h0000, lc_prod,     1'b1, err_escalated, 16'h0000},
  '{1'b1, 6'd2,  4'h0, 16'haaaa, lc_test,     1'b1, err_escalated, 16'h0000}
};

`endif

// ==== test/fuse_access_tb.sv ====
`timescale 1ns/1ps

module fuse_access_tb
  import fuse_access_pkg::*;
  import fuse_map_pkg::*;
();

  typedef struct packed {
    logic       write;
    fuse_addr_t addr;
    bus_user_t  user;
    fuse_data_t wdata;
    lc_state_e  lc;
    logic       esc;
    fuse_err_e  exp_err;
    fuse_data_t exp_rdata;
  } row_t;

  `include "fuse_access_tb_table.svh"

  // Filter policy, also handed to the DUT
  localparam fuse_addr_t LIMIT      = 6'd24;
  localparam bus_user_t  RESTRICTED = 4'h5;

  // Partition map as the model sees it
  localparam fuse_addr_t LAST_ADDR [4] = '{6'd7, 6'd23, 6'd39, 6'd63};
  localparam lc_state_e  PHASE [4]     = '{lc_test, lc_dev, lc_prod, lc_prod_end};
  localparam logic [3:0] SECRET        = 4'b0101;

  localparam int NUM_RAND    = 24;
  localparam int NUM_INTR    = 3;
  localparam int DONE_WAIT   = 8;
  localparam int CYCLE_LIMIT = 4 * (NUM_ROWS + NUM_RAND + NUM_INTR) + 50;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       cmd_valid_i;
  logic       cmd_write_i;
  fuse_addr_t cmd_addr_i;
  bus_user_t  cmd_user_i;
  fuse_data_t cmd_wdata_i;
  lc_state_e  lc_state_i;
  logic       escalate_i;
  logic       intr_en_done_i;
  logic       intr_en_error_i;
  logic       intr_clear_i;
  logic       done_o;
  fuse_err_e  err_o;
  fuse_data_t rdata_o;
  logic       intr_done_o;
  logic       intr_error_o;

  // Model state
  fuse_data_t shadow [64];
  logic [3:0] digest_set;
  logic       escalated;
  int         cycle_cnt = 0;
  int         seed = 6;

  fuse_access_top #(
    .FILTER_LIMIT    (LIMIT),
    .RESTRICTED_USER (RESTRICTED)
  ) i_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_write_i     (cmd_write_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_user_i      (cmd_user_i),
    .cmd_wdata_i     (cmd_wdata_i),
    .lc_state_i      (lc_state_i),
    .escalate_i      (escalate_i),
    .intr_en_done_i  (intr_en_done_i),
    .intr_en_error_i (intr_en_error_i),
    .intr_clear_i    (intr_clear_i),
    .done_o          (done_o),
    .err_o           (err_o),
    .rdata_o         (rdata_o),
    .intr_done_o     (intr_done_o),
    .intr_error_o    (intr_error_o)
  );

  always #20 clk_i = ~clk_i;

  // Hard stop if the run drags on
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles", cycle_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      stop_on_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic int part_index(fuse_addr_t addr);
    if (addr < 6'd8) begin
      return 0;
    end else if (addr < 6'd24) begin
      return 1;
    end else if (addr < 6'd40) begin
      return 2;
    end
    return 3;
  endfunction

  // Predicts one command and applies its effect to the shadow state
  task automatic predict_cmd(input logic write, input fuse_addr_t addr,
                             input bus_user_t user, input fuse_data_t wdata,
                             input lc_state_e lc, input logic esc,
                             output fuse_err_e exp_err, output fuse_data_t exp_rdata);
    int p;
    p = part_index(addr);
    if (esc) begin
      escalated = 1'b1;
    end
    exp_rdata = '0;
    if (escalated) begin
      exp_err = err_escalated;
    end else if (write && user == RESTRICTED && addr < LIMIT) begin
      exp_err = err_access;
    end else if (write && (lc > PHASE[p] || digest_set[p])) begin
      exp_err = err_access;
    end else if (!write && SECRET[p] && digest_set[p]) begin
      exp_err = err_access;
    end else begin
      exp_err = err_none;
    end
    if (exp_err == err_none && write) begin
      shadow[addr] = wdata;
      // Nonzero digest closes the partition
      if (addr == LAST_ADDR[p] && wdata != '0) begin
        digest_set[p] = 1'b1;
      end
    end else if (exp_err == err_none) begin
      exp_rdata = shadow[addr];
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One command every 4 cycles, checked at the negedge after done_o rises
  task automatic run_cmd(input logic write, input fuse_addr_t addr, input bus_user_t user,
                         input fuse_data_t wdata, input lc_state_e lc, input logic esc,
                         input fuse_err_e exp_err, input fuse_data_t exp_rdata);
    int waited;
    waited = 0;
    repeat (2) @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b1;
    cmd_write_i = write;
    cmd_addr_i  = addr;
    cmd_user_i  = user;
    cmd_wdata_i = wdata;
    lc_state_i  = lc;
    escalate_i  = esc;
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
    @(negedge clk_i);
    while (!done_o) begin
      if (waited == DONE_WAIT) begin
        stop_on_failure($sformatf("No done_o within %0d cycles of a command", DONE_WAIT));
      end
      waited++;
      @(negedge clk_i);
    end
    check_value("err_o", 16'(err_o), 16'(exp_err));
    check_value("rdata_o", rdata_o, exp_rdata);
  endtask

  // Table row goes through the model before it drives the DUT
  task automatic apply_row(input int idx);
    row_t       row;
    fuse_err_e  m_err;
    fuse_data_t m_rdata;
    row = ROWS[idx];
    predict_cmd(row.write, row.addr, row.user, row.wdata, row.lc, row.esc, m_err, m_rdata);
    if (m_err != row.exp_err || m_rdata != row.exp_rdata) begin
      stop_on_failure($sformatf("Table row %0d disagrees with the access rules", idx));
    end
    run_cmd(row.write, row.addr, row.user, row.wdata, row.lc, row.esc,
            row.exp_err, row.exp_rdata);
  endtask

  // Model predicts the result
  task automatic run_predicted(input logic write, input fuse_addr_t addr,
                               input bus_user_t user, input fuse_data_t wdata,
                               input lc_state_e lc);
    fuse_err_e  exp_err;
    fuse_data_t exp_rdata;
    predict_cmd(write, addr, user, wdata, lc, 1'b0, exp_err, exp_rdata);
    run_cmd(write, addr, user, wdata, lc, 1'b0, exp_err, exp_rdata);
  endtask

  task automatic check_intr(input logic exp_done, input logic exp_error);
    check_value("intr_done_o", 16'(intr_done_o), 16'(exp_done));
    check_value("intr_error_o", 16'(intr_error_o), 16'(exp_error));
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    #1;
    intr_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    intr_clear_i = 1'b0;
    @(negedge clk_i);
  endtask

  initial begin
    logic [31:0] rnd;
    bus_user_t   r_user;
    reset_i         = 1'b1;
    cmd_valid_i     = 1'b0;
    cmd_write_i     = 1'b0;
    cmd_addr_i      = '0;
    cmd_user_i      = '0;
    cmd_wdata_i     = '0;
    lc_state_i      = lc_raw;
    escalate_i      = 1'b0;
    intr_en_done_i  = 1'b0;
    intr_en_error_i = 1'b0;
    intr_clear_i    = 1'b0;
    digest_set      = '0;
    escalated       = 1'b0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Directed rows before escalation, interrupts disabled
    for (int i = 0; i < NUM_PRE; i++) begin
      apply_row(i);
    end
    @(negedge clk_i);
    check_intr(1'b0, 1'b0);

    ////////////////////////////////////////
    // Interrupts
    ////////////////////////////////////////

    @(posedge clk_i);
    #1;
    intr_en_done_i  = 1'b1;
    intr_en_error_i = 1'b1;
    run_predicted(1'b0, 6'd10, 4'h0, 16'h0000, lc_dev);
    @(negedge clk_i);
    check_intr(1'b1, 1'b0);
    pulse_clear();
    check_intr(1'b0, 1'b0);
    // Filtered write raises the error level
    run_predicted(1'b1, 6'd12, RESTRICTED, 16'h0bad, lc_dev);
    @(negedge clk_i);
    check_intr(1'b0, 1'b1);
    pulse_clear();
    check_intr(1'b0, 1'b0);
    @(posedge clk_i);
    #1;
    intr_en_done_i  = 1'b0;
    intr_en_error_i = 1'b0;
    run_predicted(1'b0, 6'd10, 4'h0, 16'h0000, lc_dev);
    @(negedge clk_i);
    check_intr(1'b0, 1'b0);

    // Random traffic against the shadow model
    for (int i = 0; i < NUM_RAND; i++) begin
      rnd    = $random(seed);
      r_user = rnd[27] ? RESTRICTED : rnd[31:28];
      run_predicted(rnd[6], rnd[5:0], r_user, rnd[23:8], lc_state_e'(rnd[26:24] % 3'd5));
    end

    // Escalated rows, then the array must match the model
    for (int i = NUM_PRE; i < NUM_ROWS; i++) begin
      apply_row(i);
    end
    for (int i = 0; i < 64; i++) begin
      check_value($sformatf("mem_q[%0d]", i), i_dut.i_engine.mem_q[i], shadow[i]);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+test
design/fuse_access_pkg.sv
design/fuse_map_pkg.sv
design/fuse_axi_filter.sv
design/fuse_part_lock.sv
design/fuse_dai_engine.sv
design/fuse_access_top.sv
test/fuse_access_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fuse access testbench with Verilator and run it
# Exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fuse_access_tb -f flist.f -o fuse_access_sim \
  && ./obj_dir/fuse_access_sim \
  || { echo "fuse access simulation did not pass"; exit 1; }
